//--- hdl/cr16_ctrl_pkg.sv
/*
 * shared encodings and control bundles for the cr16 control unit
 * opcodes, extensions, alu functions, write-back and pc modes, fsm states
 */
`default_nettype none

package cr16_ctrl_pkg;

  // ********************************************************************
  // opcodes
  // ********************************************************************

  // register/register group, function chosen by extension
  localparam logic [3:0] op_rs_rd   = 4'b0000;
  localparam logic [3:0] op_andi    = 4'b0001;
  localparam logic [3:0] op_ori     = 4'b0010;
  localparam logic [3:0] op_xori    = 4'b0011;
  // load, store and jump group
  localparam logic [3:0] op_ld_st_j = 4'b0100;
  localparam logic [3:0] op_addi    = 4'b0101;
  // shift group
  localparam logic [3:0] op_sh      = 4'b1000;
  localparam logic [3:0] op_subi    = 4'b1001;
  localparam logic [3:0] op_cmpi    = 4'b1011;
  localparam logic [3:0] op_bcond   = 4'b1100;
  localparam logic [3:0] op_movi    = 4'b1101;
  localparam logic [3:0] op_muli    = 4'b1110;
  localparam logic [3:0] op_lui     = 4'b1111;

  // ********************************************************************
  // opcode extensions
  // ********************************************************************

  // register/register
  localparam logic [3:0] ext_and    = 4'b0001;
  localparam logic [3:0] ext_or     = 4'b0010;
  localparam logic [3:0] ext_xor    = 4'b0011;
  localparam logic [3:0] ext_add    = 4'b0101;
  localparam logic [3:0] ext_sub    = 4'b1001;
  localparam logic [3:0] ext_cmp    = 4'b1011;
  localparam logic [3:0] ext_mov    = 4'b1101;
  localparam logic [3:0] ext_mul    = 4'b1110;

  // shifts, immediate forms ignore bit 0
  localparam logic [3:0] ext_lshi   = 4'b0000;
  localparam logic [3:0] ext_ashui  = 4'b0010;
  localparam logic [3:0] ext_lsh    = 4'b0100;
  localparam logic [3:0] ext_ashu   = 4'b0110;

  // load/store/jump
  localparam logic [3:0] ext_load   = 4'b0000;
  localparam logic [3:0] ext_stor   = 4'b0100;
  localparam logic [3:0] ext_jal    = 4'b1000;
  localparam logic [3:0] ext_jcond  = 4'b1100;

  // ********************************************************************
  // datapath selects
  // ********************************************************************

  // alu function select
  localparam logic [3:0] alu_add    = 4'd0;
  localparam logic [3:0] alu_sub    = 4'd1;
  localparam logic [3:0] alu_and    = 4'd2;
  localparam logic [3:0] alu_or     = 4'd3;
  localparam logic [3:0] alu_xor    = 4'd4;
  localparam logic [3:0] alu_not    = 4'd5;
  localparam logic [3:0] alu_lsh    = 4'd6;
  localparam logic [3:0] alu_ash    = 4'd7;
  localparam logic [3:0] alu_mul    = 4'd8;

  // register file write-back source
  localparam logic [2:0] wb_alu     = 3'd0;
  localparam logic [2:0] wb_mem     = 3'd1;
  localparam logic [2:0] wb_reg     = 3'd2;
  localparam logic [2:0] wb_imm     = 3'd3;
  localparam logic [2:0] wb_pc      = 3'd4;

  // next pc computation
  localparam logic [1:0] pc_increment = 2'd0;
  localparam logic [1:0] pc_offset    = 2'd1;
  localparam logic [1:0] pc_absolute  = 2'd2;

  // ********************************************************************
  // types
  // ********************************************************************

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_fetch   = 2'd1,
    st_execute = 2'd2
  } state_t;

  // instruction fields as seen by the controller
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] opcode_ext;
  } instr_fields_t;

  typedef struct packed {
    logic       alu_src;   // 1 selects the immediate
    logic [3:0] alu_sel;
  } alu_ctrl_t;

  typedef struct packed {
    logic cmp_f_en;
    logic of_f_en;
    logic z_f_en;
  } flag_en_t;

  typedef struct packed {
    logic       reg_wr_en;
    logic [2:0] write_back_sel;
    logic [1:0] pc_addr_mode;
    logic       mem_wr_en;
    flag_en_t   flags;
  } exec_ctrl_t;

  // fetch-phase strobes plus the pc update strobe
  typedef struct packed {
    logic instr_en;
    logic next_instr;
    logic pc_en;
  } fetch_ctrl_t;

  // nothing written, pc steps by one
  localparam exec_ctrl_t exec_ctrl_idle = '{
    reg_wr_en:      1'b0,
    write_back_sel: wb_alu,
    pc_addr_mode:   pc_increment,
    mem_wr_en:      1'b0,
    flags:          '0
  };

endpackage

`default_nettype wire

//--- hdl/alu_decoder.sv
/*
 * alu decoder for the cr16 control unit
 * picks the alu function and operand source from opcode and extension
 */
`default_nettype none

module alu_decoder (
  input  cr16_ctrl_pkg::instr_fields_t instr,
  output cr16_ctrl_pkg::alu_ctrl_t     alu
);
  import cr16_ctrl_pkg::*;

  // ********************************************************************
  // function and source select
  // ********************************************************************

  always_comb begin
    // register source and add unless an opcode says otherwise
    alu.alu_src = 1'b0;
    alu.alu_sel = alu_add;

    case (instr.opcode)
      // register/register ops go by extension
      op_rs_rd: begin
        case (instr.opcode_ext)
          ext_and: alu.alu_sel = alu_and;
          ext_or:  alu.alu_sel = alu_or;
          ext_xor: alu.alu_sel = alu_xor;
          ext_add: alu.alu_sel = alu_add;
          ext_sub: alu.alu_sel = alu_sub;
          // compare is a subtract with the result dropped
          ext_cmp: alu.alu_sel = alu_sub;
          ext_mul: alu.alu_sel = alu_mul;
          // mov and unused extensions
          default: alu.alu_sel = alu_add;
        endcase
      end

      // shifts
      op_sh: begin
        // immediate shift amount, bit 0 of ext is don't care
        if (instr.opcode_ext[3:1] == ext_lshi[3:1]) begin
          alu.alu_src = 1'b1;
          alu.alu_sel = alu_lsh;
        end else if (instr.opcode_ext[3:1] == ext_ashui[3:1]) begin
          alu.alu_src = 1'b1;
          alu.alu_sel = alu_ash;
        end else if (instr.opcode_ext == ext_lsh) begin
          alu.alu_sel = alu_lsh;
        end else if (instr.opcode_ext == ext_ashu) begin
          alu.alu_sel = alu_ash;
        end
      end

      // immediate arithmetic and logic
      op_andi: begin
        alu.alu_src = 1'b1;
        alu.alu_sel = alu_and;
      end
      op_ori: begin
        alu.alu_src = 1'b1;
        alu.alu_sel = alu_or;
      end
      op_xori: begin
        alu.alu_src = 1'b1;
        alu.alu_sel = alu_xor;
      end
      op_addi: begin
        alu.alu_src = 1'b1;
        alu.alu_sel = alu_add;
      end
      op_subi, op_cmpi: begin
        alu.alu_src = 1'b1;
        alu.alu_sel = alu_sub;
      end
      op_muli: begin
        alu.alu_src = 1'b1;
        alu.alu_sel = alu_mul;
      end

      // loads, stores, jumps, branches and movi leave the alu on add
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/exec_decoder.sv
/*
 * execute-phase decoder for the cr16 control unit
 * register write, write-back source, flag enables, store and next-pc mode
 */
`default_nettype none

module exec_decoder (
  input  cr16_ctrl_pkg::instr_fields_t instr,
  input  logic                         cmp_result,
  output cr16_ctrl_pkg::exec_ctrl_t    exec_raw
);
  import cr16_ctrl_pkg::*;

  // ********************************************************************
  // execute controls
  // ********************************************************************

  always_comb begin
    // nothing enabled and pc increments
    exec_raw = exec_ctrl_idle;

    case (instr.opcode)
      // register/register group
      op_rs_rd: begin
        case (instr.opcode_ext)
          // logic ops and mul only touch the zero flag
          ext_and, ext_or, ext_xor, ext_mul: begin
            exec_raw.reg_wr_en    = 1'b1;
            exec_raw.flags.z_f_en = 1'b1;
          end
          ext_add: begin
            exec_raw.reg_wr_en     = 1'b1;
            exec_raw.flags.z_f_en  = 1'b1;
            exec_raw.flags.of_f_en = 1'b1;
          end
          // subtract updates every flag
          ext_sub: begin
            exec_raw.reg_wr_en      = 1'b1;
            exec_raw.flags.z_f_en   = 1'b1;
            exec_raw.flags.of_f_en  = 1'b1;
            exec_raw.flags.cmp_f_en = 1'b1;
          end
          // compare sets flags but writes no register
          ext_cmp: begin
            exec_raw.flags.z_f_en   = 1'b1;
            exec_raw.flags.cmp_f_en = 1'b1;
          end
          // straight register copy
          ext_mov: begin
            exec_raw.reg_wr_en      = 1'b1;
            exec_raw.write_back_sel = wb_reg;
          end
          default: ;
        endcase
      end

      // loads, stores and jumps
      op_ld_st_j: begin
        case (instr.opcode_ext)
          ext_load: begin
            exec_raw.reg_wr_en      = 1'b1;
            exec_raw.write_back_sel = wb_mem;
          end
          ext_stor: begin
            exec_raw.mem_wr_en = 1'b1;
          end
          // link register gets the pc and the jump goes to the register target
          ext_jal: begin
            exec_raw.reg_wr_en      = 1'b1;
            exec_raw.write_back_sel = wb_pc;
            exec_raw.pc_addr_mode   = pc_absolute;
          end
          // taken only when the datapath compare passed
          ext_jcond: begin
            exec_raw.pc_addr_mode = cmp_result ? pc_absolute : pc_increment;
          end
          default: ;
        endcase
      end

      // every shift writes the alu result back
      op_sh: begin
        exec_raw.reg_wr_en = 1'b1;
      end

      op_andi, op_ori, op_xori, op_muli: begin
        exec_raw.reg_wr_en    = 1'b1;
        exec_raw.flags.z_f_en = 1'b1;
      end

      op_addi: begin
        exec_raw.reg_wr_en     = 1'b1;
        exec_raw.flags.z_f_en  = 1'b1;
        exec_raw.flags.of_f_en = 1'b1;
      end

      op_subi: begin
        exec_raw.reg_wr_en      = 1'b1;
        exec_raw.flags.z_f_en   = 1'b1;
        exec_raw.flags.of_f_en  = 1'b1;
        exec_raw.flags.cmp_f_en = 1'b1;
      end

      op_cmpi: begin
        exec_raw.flags.z_f_en   = 1'b1;
        exec_raw.flags.cmp_f_en = 1'b1;
      end

      // pc relative branch on compare result
      op_bcond: begin
        exec_raw.pc_addr_mode = cmp_result ? pc_offset : pc_increment;
      end

      // zero extended immediate into the register file
      op_movi: begin
        exec_raw.reg_wr_en      = 1'b1;
        exec_raw.write_back_sel = wb_imm;
      end

      // lui and unimplemented opcodes only advance the pc
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/ctrl_sequencer.sv
/*
 * fetch/execute sequencer for the cr16 control unit
 * idle after reset then alternates fetch and execute every cycle
 */
`default_nettype none

module ctrl_sequencer (
  input  logic                       clk,
  input  logic                       reset_n,
  input  cr16_ctrl_pkg::exec_ctrl_t  exec_raw,
  output cr16_ctrl_pkg::exec_ctrl_t  exec,
  output cr16_ctrl_pkg::fetch_ctrl_t fetch
);
  import cr16_ctrl_pkg::*;

  state_t state;
  state_t next_state;

  // ********************************************************************
  // state register and next state
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      st_fetch:   next_state = st_execute;
      st_execute: next_state = st_fetch;
      // idle and the unused code both restart at fetch
      default:    next_state = st_fetch;
    endcase
  end

  // ********************************************************************
  // phase outputs
  // ********************************************************************

  always_comb begin
    fetch = '0;
    exec  = exec_ctrl_idle;

    case (state)
      // load the instruction register from the pc address
      st_fetch: begin
        fetch.instr_en   = 1'b1;
        fetch.next_instr = 1'b1;
      end
      // pc updates and decoded controls pass through
      st_execute: begin
        fetch.pc_en = 1'b1;
        exec        = exec_raw;
      end
      default: ;
    endcase
  end

  // ********************************************************************
  // checks
  // ********************************************************************

  // stores and register writes only in the execute cycle right after a fetch
  a_wr_only_in_execute: assert property (
    @(posedge clk) disable iff (!reset_n)
    (exec.mem_wr_en || exec.reg_wr_en) |-> (state == st_execute) && $past(fetch.instr_en)
  );

  // pc update never overlaps an instruction load and always follows one
  a_fetch_pc_exclusive: assert property (
    @(posedge clk) disable iff (!reset_n)
    fetch.pc_en |-> !fetch.instr_en && $past(fetch.instr_en)
  );

  // once running the sequencer never falls back to idle
  a_no_return_to_idle: assert property (
    @(posedge clk) disable iff (!reset_n)
    $past(reset_n) |-> (state != st_idle)
  );

endmodule

`default_nettype wire

//--- hdl/cpu_controller.sv
/*
 * cr16 control unit top
 * sequencer plus alu and execute decoders driving the datapath strobes
 */
`default_nettype none

module cpu_controller (
  input  logic                         clk,
  input  logic                         reset_n,

  // from datapath
  input  cr16_ctrl_pkg::instr_fields_t instr,
  input  logic                         cmp_result,

  // to datapath and memory
  output cr16_ctrl_pkg::alu_ctrl_t     alu,
  output cr16_ctrl_pkg::exec_ctrl_t    exec,
  output cr16_ctrl_pkg::fetch_ctrl_t   fetch
);
  import cr16_ctrl_pkg::*;

  // decoded execute controls before phase qualification
  exec_ctrl_t exec_raw;

  // alu select follows instr in every phase
  alu_decoder u_alu_decoder (
    .instr (instr),
    .alu   (alu)
  );

  exec_decoder u_exec_decoder (
    .instr      (instr),
    .cmp_result (cmp_result),
    .exec_raw   (exec_raw)
  );

  // gates exec_raw to the execute phase and drives fetch strobes
  ctrl_sequencer u_ctrl_sequencer (
    .clk      (clk),
    .reset_n  (reset_n),
    .exec_raw (exec_raw),
    .exec     (exec),
    .fetch    (fetch)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
/*
 * testbench clock and reset source
 * 20 unit clock period, synchronous reset held low for two rising edges
 */
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset_n
);

  // free running clock, first rising edge at 10
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // released on the second edge, the dut still sees it low there
  initial begin
    reset_n = 1'b0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- include/tb_ref_model.svh
/*
 * reference model of the cr16 control unit
 * expected alu, execute and fetch controls per phase
 * include inside a module body that imports cr16_ctrl_pkg
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic alu_ctrl_t ref_alu_ctrl(input instr_fields_t i);
  alu_ctrl_t a;
  a.alu_src = (i.opcode inside {op_andi, op_ori, op_xori, op_addi, op_subi, op_cmpi,
                                op_muli}) ||
              (i.opcode == op_sh && i.opcode_ext[3:2] == 2'b00);
  a.alu_sel = alu_add;
  if (i.opcode == op_rs_rd) begin
    if (i.opcode_ext == ext_and) a.alu_sel = alu_and;
    if (i.opcode_ext == ext_or) a.alu_sel = alu_or;
    if (i.opcode_ext == ext_xor) a.alu_sel = alu_xor;
    if (i.opcode_ext inside {ext_sub, ext_cmp}) a.alu_sel = alu_sub;
    if (i.opcode_ext == ext_mul) a.alu_sel = alu_mul;
  end else if (i.opcode == op_sh) begin
    // 0..1 and 4 are logical, 2..3 and 6 arithmetic
    if (i.opcode_ext inside {4'd0, 4'd1, 4'd4}) a.alu_sel = alu_lsh;
    if (i.opcode_ext inside {4'd2, 4'd3, 4'd6}) a.alu_sel = alu_ash;
  end else begin
    if (i.opcode == op_andi) a.alu_sel = alu_and;
    if (i.opcode == op_ori) a.alu_sel = alu_or;
    if (i.opcode == op_xori) a.alu_sel = alu_xor;
    if (i.opcode inside {op_subi, op_cmpi}) a.alu_sel = alu_sub;
    if (i.opcode == op_muli) a.alu_sel = alu_mul;
  end
  return a;
endfunction

function automatic exec_ctrl_t ref_exec_ctrl(input state_t st, input instr_fields_t i,
                                             input logic cmp);
  exec_ctrl_t e;
  logic       rr;
  logic       ls;
  e  = exec_ctrl_idle;
  rr = (i.opcode == op_rs_rd);
  ls = (i.opcode == op_ld_st_j);
  if (st == st_execute) begin
    e.reg_wr_en = (rr && i.opcode_ext inside {ext_and, ext_or, ext_xor, ext_add, ext_sub,
                                              ext_mov, ext_mul}) ||
                  (ls && i.opcode_ext inside {ext_load, ext_jal}) ||
                  (i.opcode inside {op_andi, op_ori, op_xori, op_addi, op_sh, op_subi,
                                    op_movi, op_muli});
    e.flags.z_f_en = (rr && i.opcode_ext inside {ext_and, ext_or, ext_xor, ext_add,
                                                 ext_sub, ext_cmp, ext_mul}) ||
                     (i.opcode inside {op_andi, op_ori, op_xori, op_addi, op_subi,
                                       op_cmpi, op_muli});
    e.flags.of_f_en = (rr && i.opcode_ext inside {ext_add, ext_sub}) ||
                      (i.opcode inside {op_addi, op_subi});
    e.flags.cmp_f_en = (rr && i.opcode_ext inside {ext_sub, ext_cmp}) ||
                       (i.opcode inside {op_subi, op_cmpi});
    e.mem_wr_en = ls && i.opcode_ext == ext_stor;
    if (rr && i.opcode_ext == ext_mov) e.write_back_sel = wb_reg;
    if (i.opcode == op_movi) e.write_back_sel = wb_imm;
    if (ls && i.opcode_ext == ext_load) e.write_back_sel = wb_mem;
    if (ls && i.opcode_ext == ext_jal) e.write_back_sel = wb_pc;
    if (ls && (i.opcode_ext == ext_jal || (i.opcode_ext == ext_jcond && cmp)))
      e.pc_addr_mode = pc_absolute;
    if (i.opcode == op_bcond && cmp) e.pc_addr_mode = pc_offset;
  end
  return e;
endfunction

function automatic fetch_ctrl_t ref_fetch_ctrl(input state_t st);
  fetch_ctrl_t f;
  f.instr_en   = (st == st_fetch);
  f.next_instr = (st == st_fetch);
  f.pc_en      = (st == st_execute);
  return f;
endfunction

`endif

//--- bench/tb_cpu_controller.sv
/*
 * testbench for the cr16 control unit
 * directed opcode/extension sweep plus random cycles, checked on the falling edge
 */
`default_nettype none

module tb_cpu_controller;
  import cr16_ctrl_pkg::*;

  `include "tb_ref_model.svh"

  // ********************************************************************
  // run length
  // ********************************************************************

  localparam int clk_period     = 20;
  // every opcode, extension and cmp_result held for a fetch and an execute
  localparam int sweep_cycles   = 16 * 16 * 2 * 2;
  localparam int random_cycles  = 400;
  localparam int timeout_cycles = sweep_cycles + random_cycles + 20;

  logic          clk;
  logic          reset_n;
  instr_fields_t instr;
  logic          cmp_result;
  alu_ctrl_t     alu;
  exec_ctrl_t    exec;
  fetch_ctrl_t   fetch;

  // phase the controller should be in, tracked independently of the dut
  state_t        exp_state = st_idle;

  tb_clock_gen u_clock_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  cpu_controller dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .instr      (instr),
    .cmp_result (cmp_result),
    .alu        (alu),
    .exec       (exec),
    .fetch      (fetch)
  );

  // ********************************************************************
  // compare tasks
  // ********************************************************************

  task automatic check_alu(input alu_ctrl_t got, input alu_ctrl_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: alu = %b, expected %b (instr %h)", $time, got, exp, instr);
      $display("TEST FAILED");
      $fatal(1, "alu control mismatch");
    end
  endtask

  task automatic check_exec(input exec_ctrl_t got, input exec_ctrl_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: exec = %b, expected %b (instr %h, cmp_result %b)",
               $time, got, exp, instr, cmp_result);
      $display("TEST FAILED");
      $fatal(1, "execute control mismatch");
    end
  endtask

  task automatic check_fetch(input fetch_ctrl_t got, input fetch_ctrl_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: fetch = %b, expected %b (phase %s)",
               $time, got, exp, exp_state.name());
      $display("TEST FAILED");
      $fatal(1, "fetch strobe mismatch");
    end
  endtask

  // drive one instruction on the next rising edge
  task automatic drive_instr(input logic [3:0] op, input logic [3:0] ext, input logic cmp);
    @(posedge clk);
    instr      <= '{opcode: op, opcode_ext: ext};
    cmp_result <= cmp;
  endtask

  // ********************************************************************
  // expected phase and checker
  // ********************************************************************

  // idle in reset, fetch on the first edge after release, then alternate
  always @(posedge clk) begin
    if (!reset_n) begin
      exp_state <= st_idle;
    end else if (exp_state == st_fetch) begin
      exp_state <= st_execute;
    end else begin
      exp_state <= st_fetch;
    end
  end

  // falling edge sits mid cycle where inputs and state have settled
  always @(negedge clk) begin
    check_fetch(fetch, ref_fetch_ctrl(exp_state));
    check_exec(exec, ref_exec_ctrl(exp_state, instr, cmp_result));
    check_alu(alu, ref_alu_ctrl(instr));
  end

  // ********************************************************************
  // stimulus
  // ********************************************************************

  initial begin : stimulus
    logic [31:0] r;
    instr      = '0;
    cmp_result = 1'b0;
    void'($urandom(32'h90d5));

    // arbitrary instructions through reset and the idle cycle
    repeat (3) begin
      r = $urandom;
      drive_instr(r[7:4], r[3:0], r[8]);
    end

    // two cycles per combination so each one meets fetch and execute
    for (int op = 0; op < 16; op++) begin
      for (int ext = 0; ext < 16; ext++) begin
        for (int c = 0; c < 2; c++) begin
          repeat (2) drive_instr(op[3:0], ext[3:0], c[0]);
        end
      end
    end

    // random mix with a new instruction every cycle
    repeat (random_cycles) begin
      r = $urandom;
      drive_instr(r[7:4], r[3:0], r[8]);
    end

    // let the checker see the last values
    repeat (2) @(posedge clk);

    $display("TEST PASSED");
    $finish;
  end

  // ********************************************************************
  // watchdog
  // ********************************************************************

  initial begin : watchdog
    #(timeout_cycles * clk_period);
    $display("run did not finish within %0d cycles", timeout_cycles);
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/cr16_ctrl_pkg.sv
hdl/alu_decoder.sv
hdl/exec_decoder.sv
hdl/ctrl_sequencer.sv
hdl/cpu_controller.sv
bench/tb_clock_gen.sv
bench/tb_cpu_controller.sv

//--- run.sh
#!/bin/sh
# compile and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_cpu_controller \
  -f verilog.f

./obj_dir/Vtb_cpu_controller | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
